/* source/coreTypesPkg.sv */
// Core datapath types
`default_nettype none

package coreTypesPkg;

	// datapath and register index widths
	localparam int Xlen = 32;
	localparam int RegIdxW = 5;

	// canonical nop, addi x0, x0, 0
	localparam logic [Xlen-1:0] Nop = 32'h0000_0013;

	// major opcodes in use
	typedef enum logic [6:0] {
		OpcLui    = 7'b0110111,
		OpcOpImm  = 7'b0010011,
		OpcOp     = 7'b0110011,
		OpcLoad   = 7'b0000011,
		OpcStore  = 7'b0100011,
		OpcBranch = 7'b1100011,
		OpcJal    = 7'b1101111,
		OpcJalr   = 7'b1100111,
		OpcSystem = 7'b1110011
	} opcodeT;

	typedef enum logic [3:0] {
		AluAdd, AluSub, AluAnd, AluOr, AluXor, AluSlt, AluPassB, AluEq, AluNe
	} aluOpT;

	// source of an EX operand
	typedef enum logic [1:0] {
		FwdReg = 2'd0,
		FwdMem = 2'd1,
		FwdWb  = 2'd2
	} fwdSelT;

endpackage

`default_nettype wire

/* source/mmioMapPkg.sv */
// Data memory and peripheral map
`default_nettype none

package mmioMapPkg;

	// word RAM starts here
	localparam logic [31:0] RamBase = 32'h0000_0000;

	// output registers
	localparam logic [31:0] LedAddr = 32'h1000_0000;
	localparam logic [31:0] SegAddr = 32'h1000_0004;

	// read-only switch input
	localparam logic [31:0] SwitchAddr = 32'h1000_0008;

endpackage

`default_nettype wire

/* source/pipeControl.sv */
// Pipeline hazard control
`timescale 1ns/1ps
`default_nettype none

module pipeControl (
	input  wire logic clk,
	input  wire logic arstN,
	input  wire logic [coreTypesPkg::RegIdxW-1:0] idRs1,
	input  wire logic [coreTypesPkg::RegIdxW-1:0] idRs2,
	input  wire logic [coreTypesPkg::RegIdxW-1:0] exRd,
	input  wire logic exRegWrite,
	input  wire logic exIsLoad,
	input  wire logic [coreTypesPkg::RegIdxW-1:0] memRd,
	input  wire logic memRegWrite,
	input  wire logic [coreTypesPkg::RegIdxW-1:0] wbRd,
	input  wire logic wbRegWrite,
	input  wire logic exRedirect,
	input  wire logic wbHalt,
	output logic stall,
	output logic flush,
	output coreTypesPkg::fwdSelT fwdA,
	output coreTypesPkg::fwdSelT fwdB,
	output logic halted
);
	import coreTypesPkg::*;

	logic loadUse;

	// load in EX feeding the instruction in ID
	assign loadUse = exIsLoad && exRegWrite && (exRd != '0) &&
		((exRd == idRs1) || (exRd == idRs2));

	// redirect wins over stall, nothing moves once halted
	assign flush = exRedirect && !halted;
	assign stall = loadUse && !exRedirect && !halted;

	// selection for the next cycle, when EX moves to MEM and MEM to WB
	// the WB writer already reaches ID through write-through
	always_comb begin
		fwdA = FwdReg;
		fwdB = FwdReg;
		if (memRegWrite && (memRd != '0) && (memRd == idRs1))
			fwdA = FwdWb;
		if (exRegWrite && (exRd != '0) && (exRd == idRs1))
			fwdA = FwdMem;
		if (memRegWrite && (memRd != '0) && (memRd == idRs2))
			fwdB = FwdWb;
		if (exRegWrite && (exRd != '0) && (exRd == idRs2))
			fwdB = FwdMem;
	end

	// sticky halt, cleared only by reset
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			halted <= 1'b0;
		else if (wbHalt)
			halted <= 1'b1;
	end

endmodule

`default_nettype wire

/* source/instDecoder.sv */
// Instruction decoder
`timescale 1ns/1ps
`default_nettype none

module instDecoder (
	input  wire logic [coreTypesPkg::Xlen-1:0] inst,
	output logic [coreTypesPkg::RegIdxW-1:0] rs1,
	output logic [coreTypesPkg::RegIdxW-1:0] rs2,
	output logic [coreTypesPkg::RegIdxW-1:0] rd,
	output logic [coreTypesPkg::Xlen-1:0] imm,
	output coreTypesPkg::aluOpT aluOp,
	output logic useImm,
	output logic regWrite,
	output logic isLoad,
	output logic isStore,
	output logic isBranch,
	output logic isJal,
	output logic isJalr,
	output logic isHalt
);
	import coreTypesPkg::*;

	logic [2:0] funct3;
	logic [6:0] funct7;
	logic useRs1;
	logic useRs2;

	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	// unused source fields read as x0 so they never stall
	assign rs1 = useRs1 ? inst[19:15] : '0;
	assign rs2 = useRs2 ? inst[24:20] : '0;

	always_comb begin
		// default is the nop, which also covers unsupported encodings
		rd = '0;
		imm = '0;
		aluOp = AluAdd;
		useImm = 1'b1;
		regWrite = 1'b0;
		isLoad = 1'b0;
		isStore = 1'b0;
		isBranch = 1'b0;
		isJal = 1'b0;
		isJalr = 1'b0;
		isHalt = 1'b0;
		useRs1 = 1'b0;
		useRs2 = 1'b0;
		unique case (opcodeT'(inst[6:0]))
			OpcLui: begin
				// U immediate
				imm = {inst[31:12], 12'b0};
				aluOp = AluPassB;
				rd = inst[11:7];
				regWrite = 1'b1;
			end
			OpcOpImm: begin
				imm = {{20{inst[31]}}, inst[31:20]};
				rd = inst[11:7];
				useRs1 = 1'b1;
				regWrite = 1'b1;
				case (funct3)
					3'b000: aluOp = AluAdd;
					3'b010: aluOp = AluSlt;
					3'b100: aluOp = AluXor;
					3'b110: aluOp = AluOr;
					3'b111: aluOp = AluAnd;
					default: begin
						rd = '0;
						regWrite = 1'b0;
						useRs1 = 1'b0;
					end
				endcase
			end
			OpcOp: begin
				useImm = 1'b0;
				rd = inst[11:7];
				useRs1 = 1'b1;
				useRs2 = 1'b1;
				regWrite = 1'b1;
				case ({funct7, funct3})
					10'b0000000_000: aluOp = AluAdd;
					10'b0100000_000: aluOp = AluSub;
					10'b0000000_010: aluOp = AluSlt;
					10'b0000000_100: aluOp = AluXor;
					10'b0000000_110: aluOp = AluOr;
					10'b0000000_111: aluOp = AluAnd;
					default: begin
						useImm = 1'b1;
						rd = '0;
						regWrite = 1'b0;
						useRs1 = 1'b0;
						useRs2 = 1'b0;
					end
				endcase
			end
			OpcLoad: begin
				// word loads only
				if (funct3 == 3'b010) begin
					imm = {{20{inst[31]}}, inst[31:20]};
					rd = inst[11:7];
					useRs1 = 1'b1;
					regWrite = 1'b1;
					isLoad = 1'b1;
				end
			end
			OpcStore: begin
				if (funct3 == 3'b010) begin
					// S immediate
					imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
					useRs1 = 1'b1;
					useRs2 = 1'b1;
					isStore = 1'b1;
				end
			end
			OpcBranch: begin
				if (funct3[2:1] == 2'b00) begin
					// B immediate
					imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
					aluOp = funct3[0] ? AluNe : AluEq;
					useImm = 1'b0;
					useRs1 = 1'b1;
					useRs2 = 1'b1;
					isBranch = 1'b1;
				end
			end
			OpcJal: begin
				// J immediate
				imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
				rd = inst[11:7];
				regWrite = 1'b1;
				isJal = 1'b1;
			end
			OpcJalr: begin
				if (funct3 == 3'b000) begin
					imm = {{20{inst[31]}}, inst[31:20]};
					rd = inst[11:7];
					useRs1 = 1'b1;
					regWrite = 1'b1;
					isJalr = 1'b1;
				end
			end
			OpcSystem: begin
				// ebreak only
				isHalt = (inst == 32'h0010_0073);
			end
			default: begin
				isHalt = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* source/registerFile.sv */
// Integer register file
`timescale 1ns/1ps
`default_nettype none

module registerFile (
	input  wire logic clk,
	input  wire logic arstN,
	input  wire logic [coreTypesPkg::RegIdxW-1:0] rs1,
	input  wire logic [coreTypesPkg::RegIdxW-1:0] rs2,
	input  wire logic [coreTypesPkg::RegIdxW-1:0] rd,
	input  wire logic [coreTypesPkg::Xlen-1:0] wdata,
	input  wire logic wen,
	output logic [coreTypesPkg::Xlen-1:0] rdata1,
	output logic [coreTypesPkg::Xlen-1:0] rdata2
);
	import coreTypesPkg::*;

	logic [Xlen-1:0] regs [32];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			regs <= '{default: '0};
		else if (wen && (rd != '0))
			regs[rd] <= wdata;
	end

	// same-cycle write passes straight to the reader
	assign rdata1 = (rs1 == '0) ? '0 : (wen && (rd == rs1)) ? wdata : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : (wen && (rd == rs2)) ? wdata : regs[rs2];

endmodule

`default_nettype wire

/* source/execAlu.sv */
// Execute stage ALU
`timescale 1ns/1ps
`default_nettype none

module execAlu (
	input  wire logic [coreTypesPkg::Xlen-1:0] opA,
	input  wire logic [coreTypesPkg::Xlen-1:0] opB,
	input  wire coreTypesPkg::aluOpT aluOp,
	output logic [coreTypesPkg::Xlen-1:0] result,
	output logic branchTaken
);
	import coreTypesPkg::*;

	logic isEqual;
	logic lessSigned;

	assign isEqual = (opA == opB);
	assign lessSigned = $signed(opA) < $signed(opB);

	always_comb begin
		branchTaken = 1'b0;
		unique case (aluOp)
			AluAdd: result = opA + opB;
			AluSub: result = opA - opB;
			AluAnd: result = opA & opB;
			AluOr: result = opA | opB;
			AluXor: result = opA ^ opB;
			AluSlt: result = {{(Xlen-1){1'b0}}, lessSigned};
			AluPassB: result = opB;
			AluEq: begin
				branchTaken = isEqual;
				result = {{(Xlen-1){1'b0}}, isEqual};
			end
			AluNe: begin
				branchTaken = !isEqual;
				result = {{(Xlen-1){1'b0}}, !isEqual};
			end
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

/* source/dataMemIo.sv */
// Data RAM and memory-mapped I/O
`timescale 1ns/1ps
`default_nettype none

module dataMemIo #(
	parameter int RamWords = 256
) (
	input  wire logic clk,
	input  wire logic arstN,
	input  wire logic [coreTypesPkg::Xlen-1:0] memAddr,
	input  wire logic [coreTypesPkg::Xlen-1:0] memWdata,
	input  wire logic memWen,
	input  wire logic memRen,
	input  wire logic [7:0] switches,
	output logic [coreTypesPkg::Xlen-1:0] memRdata,
	output logic [7:0] led,
	output logic [coreTypesPkg::Xlen-1:0] seg
);
	import coreTypesPkg::*;
	import mmioMapPkg::*;

	localparam int IdxW = $clog2(RamWords);

	logic [Xlen-1:0] ram [RamWords];
	logic [Xlen-1:0] ramOff;
	logic [IdxW-1:0] ramIdx;
	logic inRam;

	// offset wraps high below the base, so one compare suffices
	assign ramOff = memAddr - RamBase;
	assign ramIdx = ramOff[IdxW+1:2];
	assign inRam = ramOff < Xlen'(RamWords * 4);

	always_ff @(posedge clk) begin
		if (memWen && inRam)
			ram[ramIdx] <= memWdata;
	end

	// output registers
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			led <= '0;
			seg <= '0;
		end else if (memWen) begin
			if (memAddr == LedAddr)
				led <= memWdata[7:0];
			if (memAddr == SegAddr)
				seg <= memWdata;
		end
	end

	// unmapped reads give zero
	always_comb begin
		memRdata = '0;
		if (memRen) begin
			if (inRam)
				memRdata = ram[ramIdx];
			else if (memAddr == SwitchAddr)
				memRdata = {{(Xlen-8){1'b0}}, switches};
		end
	end

endmodule

`default_nettype wire

/* source/cpuTop.sv */
// Five-stage RV32I core
`timescale 1ns/1ps
`default_nettype none

module cpuTop #(
	parameter logic [coreTypesPkg::Xlen-1:0] ResetPc = mmioMapPkg::RamBase,
	parameter int RamWords = 256
) (
	input  wire logic clk,
	input  wire logic arstN,
	input  wire logic [coreTypesPkg::Xlen-1:0] imemData,
	input  wire logic [7:0] switches,
	output logic [coreTypesPkg::Xlen-1:0] imemAddr,
	output logic [7:0] led,
	output logic [coreTypesPkg::Xlen-1:0] seg,
	output logic halted,
	output logic [31:0] retired
);
	import coreTypesPkg::*;

	// IF and IF/ID
	logic [Xlen-1:0] pc;
	logic [Xlen-1:0] idPc;
	logic [Xlen-1:0] idInst;
	logic idValid;

	// ID decode outputs
	logic [RegIdxW-1:0] decRs1;
	logic [RegIdxW-1:0] decRs2;
	logic [RegIdxW-1:0] decRd;
	logic [Xlen-1:0] decImm;
	aluOpT decAluOp;
	logic decUseImm;
	logic decRegWrite;
	logic decIsLoad;
	logic decIsStore;
	logic decIsBranch;
	logic decIsJal;
	logic decIsJalr;
	logic decIsHalt;
	logic [Xlen-1:0] rfData1;
	logic [Xlen-1:0] rfData2;

	// ID/EX
	logic [Xlen-1:0] exPc;
	logic [Xlen-1:0] exRs1Val;
	logic [Xlen-1:0] exRs2Val;
	logic [Xlen-1:0] exImm;
	logic [RegIdxW-1:0] exRd;
	aluOpT exAluOp;
	fwdSelT exFwdA;
	fwdSelT exFwdB;
	logic exUseImm;
	logic exRegWrite;
	logic exIsLoad;
	logic exIsStore;
	logic exIsBranch;
	logic exIsJal;
	logic exIsJalr;
	logic exIsHalt;
	logic exValid;

	// EX/MEM
	logic [Xlen-1:0] memAlu;
	logic [Xlen-1:0] memStoreData;
	logic [RegIdxW-1:0] memRd;
	logic memRegWrite;
	logic memIsLoad;
	logic memIsStore;
	logic memIsHalt;
	logic memValid;
	logic [Xlen-1:0] memRdata;

	// MEM/WB
	logic [Xlen-1:0] wbAlu;
	logic [Xlen-1:0] wbLoad;
	logic [RegIdxW-1:0] wbRd;
	logic wbRegWrite;
	logic wbIsLoad;
	logic wbIsHalt;
	logic wbValid;
	logic [Xlen-1:0] wbValue;

	// EX stage nets
	logic [Xlen-1:0] fwdValA;
	logic [Xlen-1:0] fwdValB;
	logic [Xlen-1:0] aluB;
	logic [Xlen-1:0] aluResult;
	logic [Xlen-1:0] exResult;
	logic [Xlen-1:0] target;
	logic branchTaken;
	logic exRedirect;

	// control nets
	logic stall;
	logic flush;
	logic haltSeen;
	fwdSelT fwdA;
	fwdSelT fwdB;

	assign imemAddr = pc;

	// stop fetching past an ebreak already in flight
	assign haltSeen = (decIsHalt && idValid) || exIsHalt || memIsHalt || wbIsHalt;

	instDecoder u_instDecoder (
		.inst(idInst), .rs1(decRs1), .rs2(decRs2), .rd(decRd), .imm(decImm),
		.aluOp(decAluOp), .useImm(decUseImm), .regWrite(decRegWrite),
		.isLoad(decIsLoad), .isStore(decIsStore), .isBranch(decIsBranch),
		.isJal(decIsJal), .isJalr(decIsJalr), .isHalt(decIsHalt)
	);

	registerFile u_registerFile (
		.clk(clk), .arstN(arstN), .rs1(decRs1), .rs2(decRs2), .rd(wbRd),
		.wdata(wbValue), .wen(wbRegWrite && !halted),
		.rdata1(rfData1), .rdata2(rfData2)
	);

	pipeControl u_pipeControl (
		.clk(clk), .arstN(arstN), .idRs1(decRs1), .idRs2(decRs2),
		.exRd(exRd), .exRegWrite(exRegWrite), .exIsLoad(exIsLoad),
		.memRd(memRd), .memRegWrite(memRegWrite),
		.wbRd(wbRd), .wbRegWrite(wbRegWrite),
		.exRedirect(exRedirect), .wbHalt(wbIsHalt),
		.stall(stall), .flush(flush), .fwdA(fwdA), .fwdB(fwdB), .halted(halted)
	);

	// operand forwarding, selection was made in ID
	assign wbValue = wbIsLoad ? wbLoad : wbAlu;
	always_comb begin
		unique case (exFwdA)
			FwdMem: fwdValA = memAlu;
			FwdWb: fwdValA = wbValue;
			default: fwdValA = exRs1Val;
		endcase
		unique case (exFwdB)
			FwdMem: fwdValB = memAlu;
			FwdWb: fwdValB = wbValue;
			default: fwdValB = exRs2Val;
		endcase
	end
	assign aluB = exUseImm ? exImm : fwdValB;

	execAlu u_execAlu (
		.opA(fwdValA), .opB(aluB), .aluOp(exAluOp),
		.result(aluResult), .branchTaken(branchTaken)
	);

	// jumps write the link address instead of the ALU result
	assign exResult = (exIsJal || exIsJalr) ? exPc + 32'd4 : aluResult;
	assign exRedirect = (exIsBranch && branchTaken) || exIsJal || exIsJalr;
	assign target = exIsJalr ? {aluResult[Xlen-1:1], 1'b0} : exPc + exImm;

	dataMemIo #(.RamWords(RamWords)) u_dataMemIo (
		.clk(clk), .arstN(arstN), .memAddr(memAlu), .memWdata(memStoreData),
		.memWen(memIsStore && !halted), .memRen(memIsLoad), .switches(switches),
		.memRdata(memRdata), .led(led), .seg(seg)
	);

	// PC and pipeline control state
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= ResetPc;
			idInst <= Nop;
			idValid <= 1'b0;
			{exRegWrite, exIsLoad, exIsStore, exIsBranch} <= '0;
			{exIsJal, exIsJalr, exIsHalt, exValid} <= '0;
			exRd <= '0;
			exAluOp <= AluAdd;
			exUseImm <= 1'b1;
			exFwdA <= FwdReg;
			exFwdB <= FwdReg;
			{memRegWrite, memIsLoad, memIsStore, memIsHalt, memValid} <= '0;
			memRd <= '0;
			{wbRegWrite, wbIsLoad, wbIsHalt, wbValid} <= '0;
			wbRd <= '0;
			retired <= '0;
		end else if (!halted) begin
			// IF/ID
			if (flush) begin
				pc <= target;
				idInst <= Nop;
				idValid <= 1'b0;
			end else if (!stall) begin
				pc <= pc + 32'd4;
				idInst <= haltSeen ? Nop : imemData;
				idValid <= !haltSeen;
			end
			// ID/EX gets a bubble on flush or stall
			if (flush || stall) begin
				{exRegWrite, exIsLoad, exIsStore, exIsBranch} <= '0;
				{exIsJal, exIsJalr, exIsHalt, exValid} <= '0;
				exRd <= '0;
			end else begin
				exRegWrite <= decRegWrite && idValid;
				exIsLoad <= decIsLoad && idValid;
				exIsStore <= decIsStore && idValid;
				exIsBranch <= decIsBranch && idValid;
				exIsJal <= decIsJal && idValid;
				exIsJalr <= decIsJalr && idValid;
				exIsHalt <= decIsHalt && idValid;
				exValid <= idValid;
				exRd <= decRd;
			end
			exAluOp <= decAluOp;
			exUseImm <= decUseImm;
			exFwdA <= fwdA;
			exFwdB <= fwdB;
			// EX/MEM
			memRegWrite <= exRegWrite;
			memIsLoad <= exIsLoad;
			memIsStore <= exIsStore;
			memIsHalt <= exIsHalt;
			memValid <= exValid;
			memRd <= exRd;
			// MEM/WB
			wbRegWrite <= memRegWrite;
			wbIsLoad <= memIsLoad;
			wbIsHalt <= memIsHalt;
			wbValid <= memValid;
			wbRd <= memRd;
			// count what leaves WB
			if (wbValid)
				retired <= retired + 32'd1;
		end
	end

	// payload registers
	always_ff @(posedge clk) begin
		if (!halted) begin
			if (!stall)
				idPc <= pc;
			exPc <= idPc;
			exRs1Val <= rfData1;
			exRs2Val <= rfData2;
			exImm <= decImm;
			memAlu <= exResult;
			memStoreData <= fwdValB;
			wbAlu <= memAlu;
			wbLoad <= memRdata;
		end
	end

endmodule

`default_nettype wire

/* verification/tbClock.sv */
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
	parameter int PeriodNs = 10,
	parameter int ResetCycles = 3
) (
	input  wire logic resetReq,
	output logic clk,
	output logic arstN
);
	// cycles spent in reset so far, zero at time zero
	int lowCycles = 0;

	initial begin
		clk = 1'b0;
		forever #(PeriodNs / 2) clk = ~clk;
	end

	// a request seen at an edge restarts the reset window
	always @(posedge clk) begin
		if (resetReq)
			lowCycles <= 0;
		else if (lowCycles < ResetCycles)
			lowCycles <= lowCycles + 1;
	end

	assign arstN = (lowCycles >= ResetCycles);

endmodule

`default_nettype wire

/* verification/cpuTop_chk.sv */
// Pipeline control assertions
`timescale 1ns/1ps
`default_nettype none

module cpuTop_chk (
	input  wire logic clk,
	input  wire logic arstN,
	input  wire logic stall,
	input  wire logic flush,
	input  wire logic halted,
	input  wire logic exIsLoad,
	input  wire logic exRedirect,
	input  wire logic [coreTypesPkg::RegIdxW-1:0] idRs1,
	input  wire logic [coreTypesPkg::RegIdxW-1:0] idRs2,
	input  wire logic [coreTypesPkg::RegIdxW-1:0] exRd,
	input  wire logic [coreTypesPkg::RegIdxW-1:0] memRd,
	input  wire logic [coreTypesPkg::RegIdxW-1:0] wbRd
);
	// failures seen so far, read by the testbench at the end
	int unsigned failCount = 0;

	// a load in EX never redirects so stall and flush never meet on IF/ID
	flushOverStall: assert property (@(posedge clk) disable iff (!arstN)
		!(exIsLoad && exRedirect))
		else begin
			failCount++;
			$error("load in EX requested a redirect");
		end

	// only reset clears the halt flag and the stage registers hold
	haltSticky: assert property (@(posedge clk) disable iff (!arstN)
		halted |=> halted && $stable({idRs1, idRs2, exRd, memRd, wbRd}))
		else begin
			failCount++;
			$error("halted fell or the pipeline moved while halted");
		end

	// one bubble per load-use hazard
	singleStall: assert property (@(posedge clk) disable iff (!arstN) stall |=> !stall)
		else begin
			failCount++;
			$error("stall held for two consecutive cycles");
		end

endmodule

bind pipeControl cpuTop_chk i_chk (
	.clk(clk),
	.arstN(arstN),
	.stall(stall),
	.flush(flush),
	.halted(halted),
	.exIsLoad(exIsLoad),
	.exRedirect(exRedirect),
	.idRs1(idRs1),
	.idRs2(idRs2),
	.exRd(exRd),
	.memRd(memRd),
	.wbRd(wbRd)
);

`default_nettype wire

/* verification/cpuTop_tb.sv */
// Pipelined core testbench
`timescale 1ns/1ps
`default_nettype none

module cpuTop_tb;

	localparam int NumRows = 6;
	localparam int ProgWords = 16;
	localparam int CyclesPerRow = 200;
	localparam logic [31:0] Seed = 32'h5890_24dd;

	// encoding fields
	localparam logic [6:0] OpImm = 7'b0010011;
	localparam logic [6:0] OpLoad = 7'b0000011;
	localparam logic [6:0] OpJalr = 7'b1100111;
	localparam logic [6:0] F7Base = 7'b0000000;
	localparam logic [6:0] F7Sub = 7'b0100000;
	localparam logic [2:0] F3Add = 3'b000;
	localparam logic [2:0] F3Slt = 3'b010;
	localparam logic [2:0] F3Xor = 3'b100;
	localparam logic [2:0] F3Or = 3'b110;
	localparam logic [2:0] F3And = 3'b111;
	localparam logic [2:0] F3Word = 3'b010;
	localparam logic [2:0] F3Beq = 3'b000;
	localparam logic [2:0] F3Bne = 3'b001;
	localparam logic [31:0] Ebreak = 32'h0010_0073;
	localparam logic [31:0] NopWord = 32'h0000_0013;

	// expected results per program
	typedef struct packed {
		logic [7:0] sw;
		logic isRand;
		logic [7:0] led;
		logic [31:0] seg;
		logic [31:0] ret;
	} rowT;

	logic clk;
	logic arstN;
	logic resetReq;
	logic [7:0] switches;
	logic [31:0] imemAddr;
	logic [31:0] imemData;
	logic [7:0] led;
	logic [31:0] seg;
	logic halted;
	logic [31:0] retired;

	logic [31:0] imem [ProgWords];
	logic [31:0] progTab [NumRows][ProgWords];
	rowT rowTab [NumRows];
	int buildRow = 0;
	int buildLen = 0;

	// instruction memory answers in the same cycle
	assign imemData = (imemAddr < 32'(ProgWords * 4)) ? imem[imemAddr[5:2]] : NopWord;

	tbClock #(.PeriodNs(10), .ResetCycles(3)) i_clock (
		.resetReq(resetReq), .clk(clk), .arstN(arstN)
	);

	cpuTop #(.ResetPc(32'h0000_0000), .RamWords(256)) i_dut (
		.clk(clk), .arstN(arstN), .imemData(imemData), .switches(switches),
		.imemAddr(imemAddr), .led(led), .seg(seg), .halted(halted), .retired(retired)
	);

	function automatic logic [31:0] rType(input logic [6:0] f7, input logic [2:0] f3,
		input int rd, input int rs1, input int rs2);
		return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
	endfunction

	function automatic logic [31:0] iType(input logic [6:0] opc, input logic [2:0] f3,
		input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
	endfunction

	// word store, sw rs2, imm(rs1)
	function automatic logic [31:0] sType(input int rs2, input int rs1, input int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] bType(input logic [2:0] f3, input int rs1, input int rs2,
		input int offset);
		return {offset[12], offset[10:5], rs2[4:0], rs1[4:0], f3, offset[4:1], offset[11],
			7'b1100011};
	endfunction

	// lui only
	function automatic logic [31:0] uType(input int rd, input logic [19:0] upper);
		return {upper, rd[4:0], 7'b0110111};
	endfunction

	// jal only
	function automatic logic [31:0] jType(input int rd, input int offset);
		return {offset[20], offset[10:1], offset[11], offset[19:12], rd[4:0], 7'b1101111};
	endfunction

	task automatic emit(input logic [31:0] word);
		progTab[buildRow][buildLen] = word;
		buildLen++;
	endtask

	// pad with nops and store the expected results
	task automatic closeRow(input logic [7:0] sw, input logic isRand, input logic [7:0] ledExp,
		input logic [31:0] segExp, input logic [31:0] retExp);
		while (buildLen < ProgWords)
			emit(NopWord);
		rowTab[buildRow] = '{sw, isRand, ledExp, segExp, retExp};
		buildRow++;
		buildLen = 0;
	endtask

	task automatic buildTable();
		// dependent ALU chain, MEM and WB forwarding
		emit(uType(10, 20'h10000));
		emit(iType(OpImm, F3Add, 1, 0, 5));
		emit(iType(OpImm, F3Add, 2, 1, 7));
		emit(rType(F7Base, F3Add, 3, 1, 2));
		emit(rType(F7Sub, F3Add, 4, 3, 1));
		emit(iType(OpImm, F3Xor, 5, 4, 'h0ff));
		emit(rType(F7Base, F3Slt, 6, 4, 5));
		emit(iType(OpImm, F3And, 7, 5, 'h0f0));
		emit(rType(F7Base, F3Or, 8, 7, 6));
		emit(iType(OpImm, F3Slt, 9, 4, -1));
		emit(rType(F7Base, F3Xor, 11, 8, 3));
		emit(rType(F7Sub, F3Add, 12, 9, 11));
		// x12 written twice, the younger value must reach the store
		emit(iType(OpImm, F3Add, 12, 12, 'h010));
		emit(iType(OpImm, F3Add, 13, 10, 0));
		emit(sType(12, 13, 4));
		emit(Ebreak);
		closeRow(8'h00, 1'b0, 8'h00, 32'hffff_ff30, 32'd16);
		// load-use on rs1 and on rs2
		emit(iType(OpImm, F3Add, 1, 0, 'h123));
		emit(sType(1, 0, 16));
		emit(uType(10, 20'h10000));
		emit(iType(OpLoad, F3Word, 3, 0, 16));
		emit(iType(OpImm, F3Add, 4, 3, 1));
		emit(iType(OpLoad, F3Word, 5, 0, 16));
		emit(rType(F7Base, F3Add, 6, 4, 5));
		emit(sType(6, 10, 4));
		emit(Ebreak);
		closeRow(8'h00, 1'b0, 8'h00, 32'h0000_0247, 32'd9);
		// RAM round trip, then led
		emit(uType(10, 20'h10000));
		emit(iType(OpImm, F3Add, 1, 0, 'h5a5));
		emit(sType(1, 0, 0));
		emit(iType(OpImm, F3Add, 2, 0, 'h03c));
		emit(sType(2, 0, 8));
		emit(iType(OpLoad, F3Word, 3, 0, 0));
		emit(iType(OpLoad, F3Word, 4, 0, 8));
		emit(rType(F7Base, F3Xor, 5, 3, 4));
		emit(sType(5, 10, 0));
		emit(sType(3, 10, 4));
		emit(Ebreak);
		closeRow(8'h00, 1'b0, 8'h99, 32'h0000_05a5, 32'd11);
		// five-pass bne loop, untaken beq, taken beq over a store
		emit(uType(10, 20'h10000));
		emit(iType(OpImm, F3Add, 1, 0, 0));
		emit(iType(OpImm, F3Add, 2, 0, 5));
		emit(rType(F7Base, F3Add, 1, 1, 2));
		emit(iType(OpImm, F3Add, 2, 2, -1));
		emit(bType(F3Bne, 2, 0, -8));
		emit(bType(F3Beq, 1, 0, 12));
		emit(sType(1, 10, 4));
		emit(bType(F3Beq, 0, 0, 8));
		emit(sType(0, 10, 4));
		emit(Ebreak);
		closeRow(8'h00, 1'b0, 8'h00, 32'd15, 32'd22);
		// call at 24 through jal, return with jalr
		emit(uType(10, 20'h10000));
		emit(iType(OpImm, F3Add, 1, 0, 3));
		emit(jType(5, 16));
		emit(rType(F7Base, F3Add, 7, 6, 8));
		emit(sType(7, 10, 4));
		emit(Ebreak);
		emit(iType(OpImm, F3Add, 6, 1, 'h40));
		emit(sType(5, 10, 0));
		emit(iType(OpJalr, F3Add, 8, 5, 0));
		emit(sType(0, 10, 0));
		closeRow(8'h00, 1'b0, 8'h0c, 32'h0000_0067, 32'd9);
		// switches to led, seg holds switches plus 0x100
		emit(uType(10, 20'h10000));
		emit(iType(OpLoad, F3Word, 1, 10, 8));
		emit(sType(1, 10, 0));
		emit(iType(OpImm, F3Add, 2, 1, 'h100));
		emit(sType(2, 10, 4));
		emit(Ebreak);
		closeRow(8'h00, 1'b1, 8'h00, 32'h0000_0100, 32'd6);
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("[FAIL] %s expected %h got %h", name, expected, actual);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic runRow(input int r);
		logic [31:0] draw;
		logic [7:0] swVal;
		logic [7:0] ledExp;
		logic [31:0] segExp;
		draw = $urandom();
		swVal = rowTab[r].isRand ? draw[7:0] : rowTab[r].sw;
		// random row copies the switches, seg adds the table constant
		ledExp = rowTab[r].isRand ? swVal : rowTab[r].led;
		segExp = rowTab[r].isRand ? rowTab[r].seg + {24'h0, swVal} : rowTab[r].seg;
		@(posedge clk);
		for (int k = 0; k < ProgWords; k++)
			imem[k] <= progTab[r][k];
		switches <= swVal;
		resetReq <= 1'b1;
		@(posedge clk);
		resetReq <= 1'b0;
		@(posedge clk);
		while (!arstN)
			@(posedge clk);
		while (!halted)
			@(posedge clk);
		checkValue("led", {24'h0, ledExp}, {24'h0, led});
		checkValue("seg", segExp, seg);
		checkValue("retired", rowTab[r].ret, retired);
		// core must stay frozen
		repeat (5) @(posedge clk);
		checkValue("halted", 32'd1, {31'd0, halted});
		checkValue("retired", rowTab[r].ret, retired);
	endtask

	initial begin
		void'($urandom(Seed));
		resetReq = 1'b0;
		switches = 8'h00;
		for (int k = 0; k < ProgWords; k++)
			imem[k] = NopWord;
		buildTable();
		for (int r = 0; r < NumRows; r++)
			runRow(r);
		if (i_dut.u_pipeControl.i_chk.failCount == 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			$display("pipeline control assertions failed %0d times",
				i_dut.u_pipeControl.i_chk.failCount);
			$display("TEST FAILED");
			$fatal(1);
		end
	end

	// watchdog over all rows
	initial begin
		repeat (NumRows * CyclesPerRow) @(posedge clk);
		$display("processor never halted within %0d cycles", NumRows * CyclesPerRow);
		$display("TEST FAILED");
		$fatal(1);
	end

endmodule

`default_nettype wire

/* sim.f */
source/coreTypesPkg.sv
source/mmioMapPkg.sv
source/pipeControl.sv
source/instDecoder.sv
source/registerFile.sv
source/execAlu.sv
source/dataMemIo.sv
source/cpuTop.sv
verification/tbClock.sv
verification/cpuTop_chk.sv
verification/cpuTop_tb.sv
